/* hdl/pet_bus_pkg.sv */
// PET bus core package with the memory map, bus-cycle slot numbers and shared structs
`default_nettype none

package pet_bus_pkg;

    // Slot number within the 16-clock bus cycle
    typedef logic [3:0] slot_t;

    localparam slot_t VIDEO_RAM_SLOT   = 4'd1;     // Video RAM fetch
    localparam slot_t VIDEO_ROM_SLOT   = 4'd3;     // Character ROM fetch
    localparam slot_t PI_FIRST_SLOT    = 4'd4;     // Host group starts, grant decided here
    localparam slot_t PI_STROBE_SLOT   = 4'd6;     // Host strobe in slots 6..7
    localparam slot_t CPU_FIRST_SLOT   = 4'd8;     // CPU window opens
    localparam slot_t PHI2_FIRST_SLOT  = 4'd12;    // phi2 high in slots 12..15

    // Phase strobes, decoded from sequencer state and slot
    typedef struct packed {
        logic video_select;
        logic video_ram_strobe;
        logic video_rom_strobe;
        logic pi_select;
        logic pi_strobe;
        logic cpu_select;
        logic phi2;
    } bus_phase_t;

    // Result of the CPU address decode
    typedef struct packed {
        logic ram;
        logic io;
        logic pia1;
        logic pia2;
        logic via;
        logic is_readonly;      // ROM image held in RAM
        logic is_mirrored;      // Video RAM, A11/A10 dropped
    } mem_decode_t;

    // One host request, held stable by the host while pending
    typedef struct packed {
        logic        rw_b;      // 1 = read
        logic [16:0] addr;
        logic [7:0]  wdata;
    } pi_req_t;

    localparam logic [15:0] PI_CTL_ADDR    = 16'hE80F;     // Bit 0 res_b, bit 1 rdy
    localparam logic [15:0] PI_STATUS_ADDR = 16'hE80E;     // Graphics jumper in bit 0

    // Memory map
    localparam logic [15:0] VRAM_FIRST     = 16'h8000;
    localparam logic [15:0] ROM_FIRST      = 16'h9000;
    localparam logic [15:0] IO_FIRST       = 16'hE800;
    localparam logic [15:0] IO_LAST        = 16'hE8FF;
    localparam logic [15:0] ROM_HIGH_FIRST = 16'hF000;
    localparam logic [15:0] PIA1_FIRST     = 16'hE810;
    localparam logic [15:0] PIA1_LAST      = 16'hE813;
    localparam logic [15:0] PIA2_FIRST     = 16'hE820;
    localparam logic [15:0] PIA2_LAST      = 16'hE823;
    localparam logic [15:0] VIA_FIRST      = 16'hE840;
    localparam logic [15:0] VIA_LAST       = 16'hE84F;
    localparam logic [16:0] VRAM_BASE      = {1'b0, VRAM_FIRST};   // Video fetch base in RAM

endpackage

`default_nettype wire

/* hdl/slot_counter.sv */
// Slot counter, free-running 4-bit position within the 16-clock bus cycle
`timescale 1ns/10ps
`default_nettype none

module slot_counter (
    input  wire logic           clk16,
    input  wire logic           reset,
    output pet_bus_pkg::slot_t  slot
);
    import pet_bus_pkg::*;

    // Wraps from 15 back to 0 on its own
    always_ff @(posedge clk16) begin
        if (reset) begin
            slot <= '0;
        end else begin
            slot <= slot + slot_t'(1);
        end
    end

    // Every phase decode downstream relies on a strict +1 walk
    property p_slot_advance;
        @(posedge clk16) disable iff (reset)
            !$past(reset) |-> (slot == slot_t'($past(slot) + slot_t'(1)));
    endproperty

    a_slot_advance: assert property (p_slot_advance)
        else $error("slot_counter: slot skipped from %0d to %0d", $past(slot), slot);

endmodule

`default_nettype wire

/* hdl/bus_sequencer.sv */
// Bus sequencer, FSM that hands each slot group to video, host or CPU and builds phase strobes
`timescale 1ns/10ps
`default_nettype none

module bus_sequencer (
    input  wire logic               clk16,
    input  wire logic               reset,
    input  pet_bus_pkg::slot_t      slot,
    input  wire logic               pi_request,
    output pet_bus_pkg::bus_phase_t phase
);
    import pet_bus_pkg::*;

    typedef enum logic [1:0] {
        VIDEO,
        PI_IDLE,
        PI_ACCESS,
        CPU
    } state_t;

    state_t state;
    state_t state_next;
    slot_t  slot_next;      // Slot of the coming clock

    assign slot_next = slot + slot_t'(1);

    // State only moves at group boundaries
    always_comb begin
        state_next = state;
        case (slot_next)
            PI_FIRST_SLOT:  state_next = pi_request ? PI_ACCESS : PI_IDLE;    // Grant check
            CPU_FIRST_SLOT: state_next = CPU;
            slot_t'(0):     state_next = VIDEO;
            default:        state_next = state;
        endcase
    end

    always_ff @(posedge clk16) begin
        if (reset) begin
            state <= VIDEO;         // Counter restarts at slot 0 too
        end else begin
            state <= state_next;
        end
    end

    // Strobes straight from state and slot, no extra register stage
    always_comb begin
        phase                  = '0;
        phase.video_select     = (state == VIDEO);
        phase.video_ram_strobe = (state == VIDEO) && (slot == VIDEO_RAM_SLOT);
        phase.video_rom_strobe = (state == VIDEO) && (slot == VIDEO_ROM_SLOT);
        phase.pi_select        = (state == PI_ACCESS);
        phase.pi_strobe        = (state == PI_ACCESS) && (slot >= PI_STROBE_SLOT);  // 6..7
        phase.cpu_select       = (state == CPU);
        phase.phi2             = (state == CPU) && (slot >= PHI2_FIRST_SLOT);      // 12..15
    end

    // Never two bus owners at once
    a_select_onehot: assert property (
        @(posedge clk16) disable iff (reset)
            $onehot0({phase.video_select, phase.pi_select, phase.cpu_select}))
        else $error("bus_sequencer: more than one select active");

    // phi2 opens only at slot 12 inside the CPU window
    a_phi2_in_cpu: assert property (
        @(posedge clk16) disable iff (reset)
            $rose(phase.phi2) |-> (state == CPU) && (slot == PHI2_FIRST_SLOT))
        else $error("bus_sequencer: phi2 rose outside the CPU window");

endmodule

`default_nettype wire

/* hdl/pi_bridge.sv */
// Host bridge, pending/done handshake, CPU reset/ready control register and read-data latch
`timescale 1ns/10ps
`default_nettype none

module pi_bridge #(
    parameter logic [15:0] CTL_ADDR    = pet_bus_pkg::PI_CTL_ADDR,
    parameter logic [15:0] STATUS_ADDR = pet_bus_pkg::PI_STATUS_ADDR
) (
    input  wire logic               clk16,
    input  wire logic               reset,
    input  pet_bus_pkg::bus_phase_t phase,
    input  pet_bus_pkg::pi_req_t    pi_req,
    input  wire logic               pi_pending,
    input  wire logic               gfx,
    input  wire logic [7:0]         bus_data_in,
    output logic                    pi_request,
    output logic                    pi_done,
    output logic [7:0]              pi_rdata,
    output logic                    res_b,
    output logic                    cpu_rdy
);
    logic strobe_q;         // pi_strobe seen on the previous clock
    logic strobe_last;      // Final clock of the strobe, slot 7
    logic hit_ctl;
    logic hit_status;

    assign strobe_last = phase.pi_strobe && strobe_q;
    assign hit_ctl     = (pi_req.addr == {1'b0, CTL_ADDR});
    assign hit_status  = (pi_req.addr == {1'b0, STATUS_ADDR});

    // Ask for a slot until the current request is done
    assign pi_request = pi_pending && !pi_done;

    always_ff @(posedge clk16) begin
        if (reset) begin
            strobe_q <= 1'b0;
            pi_done  <= 1'b0;
            res_b    <= 1'b0;       // CPU held in reset until the host releases it
            cpu_rdy  <= 1'b0;
        end else begin
            strobe_q <= phase.pi_strobe;
            if (strobe_last) begin
                pi_done <= 1'b1;
            end else if (!pi_pending) begin
                pi_done <= 1'b0;    // Host has seen done and let go
            end
            // Write also lands in RAM below, as on the board
            if (strobe_last && !pi_req.rw_b && hit_ctl) begin
                res_b   <= pi_req.wdata[0];
                cpu_rdy <= pi_req.wdata[1];
            end
        end
    end

    // Captured at the end of a read strobe
    always_ff @(posedge clk16) begin
        if (strobe_last && pi_req.rw_b) begin
            pi_rdata <= hit_status ? {7'b0, gfx} : bus_data_in;
        end
    end

    // A host that drops pending mid-access would get an unrequested done
    a_done_needs_pending: assert property (
        @(posedge clk16) disable iff (reset)
            $rose(pi_done) |-> $past(pi_pending))
        else $error("pi_bridge: pi_done rose without pi_pending");

endmodule

`default_nettype wire

/* hdl/address_decoder.sv */
// Address decoder, combinational memory-map decode of the CPU address
`timescale 1ns/10ps
`default_nettype none

module address_decoder (
    input  wire logic [15:0]         cpu_addr,
    output pet_bus_pkg::mem_decode_t decode
);
    import pet_bus_pkg::*;

    logic in_io;
    logic in_vram;
    logic in_rom;

    assign in_io   = (cpu_addr >= IO_FIRST) && (cpu_addr <= IO_LAST);
    assign in_vram = (cpu_addr >= VRAM_FIRST) && (cpu_addr < ROM_FIRST);
    // Two ROM areas, either side of the I/O block
    assign in_rom  = ((cpu_addr >= ROM_FIRST) && (cpu_addr < IO_FIRST))
                  || (cpu_addr >= ROM_HIGH_FIRST);

    always_comb begin
        decode = '0;
        if (cpu_addr < VRAM_FIRST) begin
            decode.ram = 1'b1;                  // Plain RAM
        end else if (in_vram) begin
            decode.ram         = 1'b1;
            decode.is_mirrored = 1'b1;          // 1KB/2KB image repeated over 4KB
        end else if (in_io) begin
            decode.io   = 1'b1;                 // RAM stays off here
            decode.pia1 = (cpu_addr >= PIA1_FIRST) && (cpu_addr <= PIA1_LAST);
            decode.pia2 = (cpu_addr >= PIA2_FIRST) && (cpu_addr <= PIA2_LAST);
            decode.via  = (cpu_addr >= VIA_FIRST) && (cpu_addr <= VIA_LAST);
        end else if (in_rom) begin
            decode.ram         = 1'b1;
            decode.is_readonly = 1'b1;          // ROM images loaded into RAM by the host
        end
        // E900..EFFF left undecoded, open bus
    end

endmodule

`default_nettype wire

/* hdl/memory_control.sv */
// Memory control, shared SRAM strobes and address steering, chip selects and bus direction
`timescale 1ns/10ps
`default_nettype none

module memory_control #(
    parameter logic [16:0] VIDEO_BASE = pet_bus_pkg::VRAM_BASE
) (
    input  pet_bus_pkg::bus_phase_t  phase,
    input  pet_bus_pkg::mem_decode_t decode,
    input  wire logic [15:0]         cpu_addr,
    input  wire logic                cpu_rw_b,
    input  pet_bus_pkg::pi_req_t     pi_req,
    input  wire logic [11:0]         video_addr,
    input  wire logic                cpu_rdy,
    output logic [16:0]              ram_addr,
    output logic                     ram_ce_b,
    output logic                     ram_oe_b,
    output logic                     ram_we_b,
    output logic                     cpu_be,
    output logic                     pia1_cs2_b,
    output logic                     pia2_cs2_b,
    output logic                     via_cs2_b,
    output logic                     io_oe_b,
    output logic                     bus_rw_b_out,
    output logic                     bus_data_oe
);
    logic pi_read;
    logic pi_write;
    logic cpu_read;
    logic cpu_write;
    logic ram_ce;
    logic ram_oe;
    logic ram_we;

    assign pi_read   = phase.pi_strobe && pi_req.rw_b;
    assign pi_write  = phase.pi_strobe && !pi_req.rw_b;
    assign cpu_read  = phase.phi2 && cpu_rw_b;
    assign cpu_write = phase.phi2 && !cpu_rw_b;

    // CPU drives the bus only in its window and while ready
    assign cpu_be = phase.cpu_select && cpu_rdy;

    assign pia1_cs2_b = !(decode.pia1 && cpu_be);
    assign pia2_cs2_b = !(decode.pia2 && cpu_be);
    assign via_cs2_b  = !(decode.via && cpu_be);
    assign io_oe_b    = !(decode.io && cpu_be);

    // Host and video own the address outside the CPU window
    always_comb begin
        if (phase.pi_select) begin
            ram_addr = pi_req.addr;                             // Full 128KB reach
        end else if (phase.video_select) begin
            ram_addr = VIDEO_BASE + {5'b0, video_addr};
        end else if (decode.is_mirrored) begin
            ram_addr = {1'b0, cpu_addr[15:12], 2'b00, cpu_addr[9:0]};  // Fold A11/A10
        end else begin
            ram_addr = {1'b0, cpu_addr};
        end
    end

    assign ram_ce = decode.ram || !phase.cpu_select;
    assign ram_oe = pi_read || phase.video_ram_strobe || phase.video_rom_strobe
                 || (cpu_read && cpu_be);
    assign ram_we = pi_write || (cpu_write && cpu_be && !decode.is_readonly);  // ROM guard

    assign ram_ce_b = !ram_ce;
    assign ram_oe_b = !ram_oe;
    assign ram_we_b = !ram_we;

    // Core drives rw_b and data only for a host write
    assign bus_rw_b_out = !pi_write;
    assign bus_data_oe  = pi_write;

    // Relies on the sequencer never overlapping host strobe, video strobes and phi2
    always_comb begin
        assert (!(ram_oe && ram_we))
            else $error("memory_control: RAM output and write enables active together");
    end

endmodule

`default_nettype wire

/* hdl/pet_bus.sv */
// PET bus core top, slot timing, host bridge, address decode and memory control wired up
`timescale 1ns/10ps
`default_nettype none

module pet_bus #(
    parameter logic [15:0] CTL_ADDR    = pet_bus_pkg::PI_CTL_ADDR,
    parameter logic [15:0] STATUS_ADDR = pet_bus_pkg::PI_STATUS_ADDR,
    parameter logic [16:0] VIDEO_BASE  = pet_bus_pkg::VRAM_BASE
) (
    input  wire logic            clk16,             // 16 MHz master clock
    input  wire logic            reset,
    // CPU side
    input  wire logic [15:0]     cpu_addr,
    input  wire logic            cpu_rw_b,
    output logic                 cpu_be,
    output logic                 phi2,              // 1 MHz CPU clock
    output logic                 res_b,
    output logic                 cpu_rdy,
    // Host side
    input  pet_bus_pkg::pi_req_t pi_req,
    input  wire logic            pi_pending,
    output logic                 pi_done,
    output logic [7:0]           pi_rdata,
    input  wire logic            gfx,               // Graphics jumper
    // Video
    input  wire logic [11:0]     video_addr,
    output logic                 video_ram_strobe,
    output logic                 video_rom_strobe,
    // Shared bus and RAM
    input  wire logic [7:0]      bus_data_in,
    output logic [16:0]          ram_addr,
    output logic                 ram_ce_b,
    output logic                 ram_oe_b,
    output logic                 ram_we_b,
    output logic                 pia1_cs2_b,
    output logic                 pia2_cs2_b,
    output logic                 via_cs2_b,
    output logic                 io_oe_b,
    output logic                 bus_rw_b_out,
    output logic                 bus_data_oe
);
    import pet_bus_pkg::*;

    slot_t       slot;
    bus_phase_t  phase;
    mem_decode_t decode;
    logic        pi_request;

    assign phi2             = phase.phi2;
    assign video_ram_strobe = phase.video_ram_strobe;
    assign video_rom_strobe = phase.video_rom_strobe;

    slot_counter u_slot_counter (.clk16(clk16), .reset(reset), .slot(slot));

    bus_sequencer u_bus_sequencer (.clk16(clk16), .reset(reset), .slot(slot),
        .pi_request(pi_request), .phase(phase));

    pi_bridge #(.CTL_ADDR(CTL_ADDR), .STATUS_ADDR(STATUS_ADDR)) u_pi_bridge (
        .clk16(clk16), .reset(reset), .phase(phase), .pi_req(pi_req),
        .pi_pending(pi_pending), .gfx(gfx), .bus_data_in(bus_data_in),
        .pi_request(pi_request), .pi_done(pi_done), .pi_rdata(pi_rdata),
        .res_b(res_b), .cpu_rdy(cpu_rdy));

    address_decoder u_address_decoder (.cpu_addr(cpu_addr), .decode(decode));

    memory_control #(.VIDEO_BASE(VIDEO_BASE)) u_memory_control (
        .phase(phase), .decode(decode), .cpu_addr(cpu_addr), .cpu_rw_b(cpu_rw_b),
        .pi_req(pi_req), .video_addr(video_addr), .cpu_rdy(cpu_rdy),
        .ram_addr(ram_addr), .ram_ce_b(ram_ce_b), .ram_oe_b(ram_oe_b),
        .ram_we_b(ram_we_b), .cpu_be(cpu_be), .pia1_cs2_b(pia1_cs2_b),
        .pia2_cs2_b(pia2_cs2_b), .via_cs2_b(via_cs2_b), .io_oe_b(io_oe_b),
        .bus_rw_b_out(bus_rw_b_out), .bus_data_oe(bus_data_oe));

endmodule

`default_nettype wire

/* test/pet_bus_tb.sv */
// Testbench for the PET bus core, directed tests against a 128KB SRAM model
`timescale 1ns/10ps
`default_nettype none

module pet_bus_tb;
    import pet_bus_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 5;
    localparam int WATCHDOG_NS  = NUM_TESTS * 40 * 16 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic        clk16, reset, cpu_rw_b, pi_pending, gfx;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_wdata;                         // Byte the CPU would put on the bus
    logic [11:0] video_addr;
    logic [7:0]  bus_data_in;
    pi_req_t     pi_req;
    logic        cpu_be, phi2, res_b, cpu_rdy, pi_done;
    logic        video_ram_strobe, video_rom_strobe;
    logic [7:0]  pi_rdata;
    logic [16:0] ram_addr;
    logic        ram_ce_b, ram_oe_b, ram_we_b, io_oe_b;
    logic        pia1_cs2_b, pia2_cs2_b, via_cs2_b, bus_rw_b_out, bus_data_oe;

    int     errors, checks, tests_run, tests_failed;
    integer seed;
    slot_t  ref_slot;                               // Expected slot, counted from reset release
    logic [7:0] sram [0:131071];

    pet_bus dut_i (.*);

    initial begin
        clk16 = 1'b0;
        forever #(CLK_PERIOD / 2) clk16 = ~clk16;
    end

    always @(posedge clk16) begin
        ref_slot <= reset ? 4'd0 : ref_slot + 4'd1;
    end

    // SRAM model, fill depends on every address bit
    initial begin
        for (int i = 0; i < 131072; i++) begin
            sram[i] <= i[7:0] ^ i[15:8] ^ {7'b0, i[16]};
        end
    end

    assign bus_data_in = (!ram_ce_b && !ram_oe_b) ? sram[ram_addr] : 8'hFF;   // Pull-ups when idle

    always @(posedge clk16) begin
        if (!ram_ce_b && !ram_we_b) begin
            sram[ram_addr] <= bus_data_oe ? pi_req.wdata : cpu_wdata;      // Host or CPU drives data
        end
    end

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [16:0] got, input logic [16:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_decode(input mem_decode_t got, input mem_decode_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Memory map as the board documents it
    function automatic mem_decode_t expected_decode(input logic [15:0] a);
        mem_decode_t d;
        d = '0;
        if (a < 16'h8000) begin
            d.ram = 1'b1;
        end else if (a < 16'h9000) begin
            d.ram         = 1'b1;
            d.is_mirrored = 1'b1;
        end else if (a >= 16'hE800 && a <= 16'hE8FF) begin
            d.io   = 1'b1;
            d.pia1 = (a >= 16'hE810) && (a <= 16'hE813);
            d.pia2 = (a >= 16'hE820) && (a <= 16'hE823);
            d.via  = (a >= 16'hE840) && (a <= 16'hE84F);
        end else if (a < 16'hE800 || a >= 16'hF000) begin
            d.ram         = 1'b1;
            d.is_readonly = 1'b1;
        end
        return d;
    endfunction

    // One pending/done transaction, returns the latched read byte
    task automatic host_access(input logic rw_b, input logic [16:0] addr,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        int n;
        int drive_clks;                             // Clocks with the core driving host data
        n          = 0;
        drive_clks = 0;
        @(posedge clk16);
        #2;
        pi_req.rw_b  = rw_b;
        pi_req.addr  = addr;
        pi_req.wdata = wdata;
        pi_pending   = 1'b1;
        @(negedge clk16);
        while (!pi_done && n < 48) begin           // At most one bus cycle of waiting plus the access
            if (!bus_rw_b_out || bus_data_oe) begin
                drive_clks++;
                check_bit(bus_rw_b_out, 1'b0, "bus_rw_b_out while host data is driven");
                check_bit(bus_data_oe, 1'b1, "bus_data_oe while bus_rw_b_out is low");
                check_bit(ref_slot == 4'd6 || ref_slot == 4'd7, 1'b1,
                    $sformatf("host bus drive in slot %0d", ref_slot));
            end
            @(negedge clk16);
            n++;
        end
        if (!pi_done) begin
            errors++;
            $display("Host request to %h got no pi_done within %0d clocks", addr, n);
        end
        check_bit(drive_clks == (rw_b ? 0 : 2), 1'b1,
            $sformatf("host data driven for %0d clocks with rw_b %b", drive_clks, rw_b));
        rdata = pi_rdata;
        @(posedge clk16);
        #2;
        pi_pending = 1'b0;
        @(negedge clk16);
        check_bit(pi_done, 1'b1, "pi_done in the clock pending drops");
        @(negedge clk16);
        check_bit(pi_done, 1'b0, "pi_done after pending dropped");
    endtask

    // Present a CPU address and return at a sample point inside phi2
    task automatic cpu_access(input logic [15:0] addr, input logic rw_b, input logic [7:0] data);
        int n;
        n = 0;
        @(posedge clk16);
        #2;
        cpu_addr  = addr;
        cpu_rw_b  = rw_b;
        cpu_wdata = data;
        @(negedge clk16);
        while (!phi2 && n < 32) begin
            @(negedge clk16);
            n++;
        end
        if (!phi2) begin
            errors++;
            $display("phi2 never went high while the CPU accessed %h", addr);
        end
    endtask

    task automatic release_cpu_bus();
        @(posedge clk16);
        #2;
        cpu_rw_b = 1'b1;
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        if (errors > start) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - start);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    task automatic phase_pattern();
        int start;
        start = errors;
        @(negedge clk16);
        check_bit(cpu_be, 1'b0, "cpu_be after reset");
        check_bit(pi_done, 1'b0, "pi_done after reset");
        check_bit(res_b, 1'b0, "res_b after reset");
        check_bit(cpu_rdy, 1'b0, "cpu_rdy after reset");
        for (int k = 0; k < 32; k++) begin        // Two full bus cycles
            check_bit(phi2, ref_slot >= 4'd12, $sformatf("phi2 in slot %0d", ref_slot));
            check_bit(video_ram_strobe, ref_slot == 4'd1,
                $sformatf("vram strobe slot %0d", ref_slot));
            check_bit(video_rom_strobe, ref_slot == 4'd3,
                $sformatf("vrom strobe slot %0d", ref_slot));
            check_bit(ram_oe_b, !(ref_slot == 4'd1 || ref_slot == 4'd3),
                $sformatf("ram_oe_b in slot %0d", ref_slot));
            check_bit(ram_we_b, 1'b1, $sformatf("ram_we_b in slot %0d", ref_slot));
            @(negedge clk16);
        end
        finish_test("phase pattern", start);
    endtask

    task automatic host_ram_roundtrip();
        int start;
        logic [31:0] r;
        logic [16:0] addr;
        logic [7:0]  rd;
        start = errors;
        r     = $random(seed);
        addr  = {2'b00, r[14:0]};
        host_access(1'b0, addr, r[23:16], rd);
        host_access(1'b1, addr, 8'h00, rd);
        check_byte(rd, r[23:16], $sformatf("host read of %h", addr));
        finish_test("host RAM write and read", start);
    endtask

    task automatic control_and_status();
        int start;
        logic [7:0] rd;
        start = errors;
        host_access(1'b0, 17'h0E80F, 8'h03, rd);
        check_bit(res_b, 1'b1, "res_b after control write of 3");
        check_bit(cpu_rdy, 1'b1, "cpu_rdy after control write of 3");
        host_access(1'b0, 17'h0E80F, 8'h00, rd);
        check_bit(res_b, 1'b0, "res_b after control write of 0");
        check_bit(cpu_rdy, 1'b0, "cpu_rdy after control write of 0");
        for (int g = 0; g < 2; g++) begin
            @(posedge clk16);
            #2;
            gfx = g[0];
            host_access(1'b1, 17'h0E80E, 8'h00, rd);
            check_byte(rd, {7'b0, g[0]}, $sformatf("status read with gfx %0d", g));
        end
        finish_test("control and status", start);
    endtask

    task automatic chip_select_decode();
        int start;
        logic [31:0] r;
        logic [15:0] addr;
        logic [7:0]  rd;
        mem_decode_t exp;
        mem_decode_t obs;
        start = errors;
        host_access(1'b0, 17'h0E80F, 8'h03, rd);    // CPU out of reset and ready
        for (int k = 0; k < 24; k++) begin
            r = $random(seed);
            case (r[18:16])                         // Bias toward the small I/O windows
                3'd1:    addr = {8'hE8, r[7:0]};
                3'd2:    addr = {14'h3A04, r[1:0]};
                3'd3:    addr = {14'h3A08, r[1:0]};
                3'd4:    addr = {12'hE84, r[3:0]};
                3'd5:    addr = {4'h8, r[11:0]};
                3'd6:    addr = {4'hF, r[11:0]};
                default: addr = r[15:0];
            endcase
            if (addr[15:12] == 4'h8) begin
                addr[11] = 1'b1;                    // Video fold then moves ram_addr
            end
            cpu_access(addr, 1'b0, r[31:24]);
            exp             = expected_decode(addr);
            obs.ram         = !ram_ce_b;
            obs.io          = !io_oe_b;
            obs.pia1        = !pia1_cs2_b;
            obs.pia2        = !pia2_cs2_b;
            obs.via         = !via_cs2_b;
            obs.is_readonly = !ram_ce_b && ram_we_b;    // RAM selected but write blocked
            obs.is_mirrored = (ram_addr != {1'b0, addr});
            check_decode(obs, exp, $sformatf("decode of %h", addr));
        end
        release_cpu_bus();
        host_access(1'b0, 17'h0E80F, 8'h01, rd);    // Ready low, selects must stay off
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            cpu_access({8'hE8, 2'b00, r[5:0]}, 1'b1, 8'h00);
            check_bit(cpu_be, 1'b0, "cpu_be with cpu_rdy low");
            check_bit(pia1_cs2_b & pia2_cs2_b & via_cs2_b & io_oe_b, 1'b1,
                $sformatf("selects for %h with cpu_rdy low", cpu_addr));
        end
        finish_test("chip-select decode", start);
    endtask

    task automatic readonly_and_mirror();
        int start;
        logic [31:0] r;
        logic [15:0] addr;
        logic [7:0]  rd;
        start = errors;
        host_access(1'b0, 17'h0E80F, 8'h03, rd);
        r    = $random(seed);
        addr = {4'hA, r[11:0]};
        cpu_access(addr, 1'b0, r[23:16]);
        check_bit(ram_we_b, 1'b1, $sformatf("ram_we_b on ROM write to %h", addr));
        addr = {4'h8, 2'b11, r[9:0]};               // A11/A10 set so folding is visible
        cpu_access(addr, 1'b1, 8'h00);
        check_addr(ram_addr, {1'b0, addr} & 17'h1F3FF, $sformatf("ram_addr for video %h", addr));
        addr = {1'b0, r[30:16]};
        cpu_access(addr, 1'b0, r[7:0]);
        check_bit(ram_we_b, 1'b0, $sformatf("ram_we_b on RAM write to %h", addr));
        check_addr(ram_addr, {1'b0, addr}, $sformatf("ram_addr for RAM write to %h", addr));
        release_cpu_bus();
        host_access(1'b1, {1'b0, addr}, 8'h00, rd);
        check_byte(rd, r[7:0], $sformatf("host read back of CPU write to %h", addr));
        finish_test("read-only and mirroring", start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before the tests finished", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed       = 32'he085;
        reset      = 1'b1;
        cpu_addr   = 16'h0000;
        cpu_rw_b   = 1'b1;
        cpu_wdata  = 8'h00;
        pi_req     = '0;
        pi_pending = 1'b0;
        gfx        = 1'b0;
        video_addr = 12'h000;
        repeat (RESET_CYCLES) @(posedge clk16);
        #2;
        reset = 1'b0;
        phase_pattern();
        host_ram_roundtrip();
        control_and_status();
        chip_select_decode();
        readonly_and_mirror();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
            tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pet_bus.f */
hdl/pet_bus_pkg.sv
hdl/slot_counter.sv
hdl/bus_sequencer.sv
hdl/pi_bridge.sv
hdl/address_decoder.sv
hdl/memory_control.sv
hdl/pet_bus.sv
test/pet_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the PET bus testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f pet_bus.f --top-module pet_bus_tb -o pet_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pet_bus_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "Simulation log has no final status"
    exit 1
fi
exit 0
